// ==== istore_cfg.svh ====
`ifndef ISTORE_CFG_SVH
`define ISTORE_CFG_SVH

// one instruction word, also the AXI data bus
`define ISTORE_DATA_WIDTH 32

// AXI byte address
`define ISTORE_AXI_ADDR_WIDTH 16

`define ISTORE_ID_WIDTH 4

// words in the store, power of two only
`define ISTORE_DEPTH 256

// log2 of the depth
`define ISTORE_WORD_ADDR_WIDTH 8

`endif

// ==== verilog/istore_pkg.sv ====
`default_nettype none
`include "istore_cfg.svh"

package istore_pkg;

    typedef logic [`ISTORE_DATA_WIDTH-1:0] data_t;
    typedef logic [`ISTORE_AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [`ISTORE_WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [`ISTORE_ID_WIDTH-1:0] axi_id_t;
    typedef logic [7:0] burst_len_t; // beats minus one
    typedef logic [1:0] burst_t;

    typedef enum logic [1:0] {wr_idle, wr_addr, wr_data, wr_resp} write_state_t;
    typedef enum logic [1:0] {rd_idle, rd_addr, rd_data} read_state_t;

    // word address of the beat after addr
    function automatic word_addr_t next_word_addr(word_addr_t addr, burst_t burst,
                                                  burst_len_t len);
        word_addr_t mask;
        mask = word_addr_t'(len); // wrap window is len+1 words
        case (burst)
            2'b00: next_word_addr = addr; // fixed
            2'b10: next_word_addr = (addr & ~mask) | ((addr + word_addr_t'(1)) & mask);
            default: next_word_addr = addr + word_addr_t'(1); // incr and reserved
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/istore_write_channel.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "istore_cfg.svh"

module istore_write_channel (
    input logic clock_in,
    input logic reset_in,
    input istore_pkg::axi_id_t awid,
    input istore_pkg::axi_addr_t awaddr,
    input istore_pkg::burst_len_t awlen,
    input istore_pkg::burst_t awburst,
    input logic awvalid,
    output logic awready,
    input istore_pkg::data_t wdata,
    input logic wlast,
    input logic wvalid,
    output logic wready,
    output istore_pkg::axi_id_t bid,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    output logic write_request,
    input logic write_grant,
    output logic mem_write_enable,
    output istore_pkg::word_addr_t mem_write_address,
    output istore_pkg::data_t mem_write_data
);
    import istore_pkg::*;

    write_state_t state;
    word_addr_t word_addr; // address of the next beat
    burst_len_t len_q;
    burst_t burst_q;
    axi_id_t id_q;

    logic aw_fire;
    logic w_fire;
    logic b_fire;

    assign awready = (state == wr_addr);
    assign wready = (state == wr_data);
    assign bvalid = (state == wr_resp);

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;
    assign b_fire = bvalid && bready;

    // wants the store while awvalid waits, let go on the B transfer
    assign write_request = (state == wr_idle) ? awvalid : !b_fire;

    assign bid = id_q;
    assign bresp = 2'b00; // OKAY

    // beats go straight into the store
    assign mem_write_enable = w_fire;
    assign mem_write_address = word_addr;
    assign mem_write_data = wdata;

    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            state <= wr_idle;
        end else begin
            case (state)
                wr_idle: begin
                    if (write_grant && awvalid) begin
                        state <= wr_addr;
                    end
                end
                wr_addr: begin
                    if (aw_fire) begin
                        state <= wr_data;
                    end
                end
                wr_data: begin
                    if (w_fire && wlast) begin // awlen is not checked
                        state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (b_fire) begin
                        state <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    // burst context and beat address
    always_ff @(posedge clock_in) begin
        if (aw_fire) begin
            id_q <= awid;
            word_addr <= awaddr[`ISTORE_WORD_ADDR_WIDTH+1:2]; // drop byte bits
            len_q <= awlen;
            burst_q <= awburst;
        end else if (w_fire) begin
            word_addr <= next_word_addr(word_addr, burst_q, len_q);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/istore_read_channel.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "istore_cfg.svh"

module istore_read_channel (
    input logic clock_in,
    input logic reset_in,
    input istore_pkg::axi_id_t arid,
    input istore_pkg::axi_addr_t araddr,
    input istore_pkg::burst_len_t arlen,
    input istore_pkg::burst_t arburst,
    input logic arvalid,
    output logic arready,
    output istore_pkg::axi_id_t rid,
    output istore_pkg::data_t rdata,
    output logic [1:0] rresp,
    output logic rlast,
    output logic rvalid,
    input logic rready,
    output logic read_request,
    input logic read_grant,
    output logic mem_read_enable,
    output istore_pkg::word_addr_t mem_read_address,
    input istore_pkg::data_t mem_read_data
);
    import istore_pkg::*;

    read_state_t state;
    word_addr_t word_addr;
    burst_len_t len_q;
    burst_t burst_q;
    axi_id_t id_q;
    burst_len_t issue_count; // store reads issued so far
    logic issue_done;

    logic ar_fire;
    logic r_fire;

    assign arready = (state == rd_addr);
    assign ar_fire = arvalid && arready;
    assign r_fire = rvalid && rready;

    assign read_request = (state == rd_idle) ? arvalid : !(r_fire && rlast);

    // next read only once the R slot is free or being emptied
    assign mem_read_enable = (state == rd_data) && !issue_done && (!rvalid || rready);
    assign mem_read_address = word_addr;

    assign rid = id_q;
    assign rresp = 2'b00; // OKAY
    assign rdata = mem_read_data; // store output holds under stall

    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            state <= rd_idle;
            issue_count <= '0;
            issue_done <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
        end else begin
            case (state)
                rd_idle: begin
                    if (read_grant && arvalid) begin
                        state <= rd_addr;
                    end
                end
                rd_addr: begin
                    if (ar_fire) begin
                        state <= rd_data;
                        issue_count <= '0;
                        issue_done <= 1'b0;
                    end
                end
                rd_data: begin
                    if (r_fire && rlast) begin
                        state <= rd_idle;
                    end
                end
                default: state <= rd_idle;
            endcase

            if (mem_read_enable) begin
                rvalid <= 1'b1;
                rlast <= (issue_count == len_q);
                issue_done <= (issue_count == len_q);
                issue_count <= issue_count + burst_len_t'(1);
            end else if (r_fire) begin
                rvalid <= 1'b0;
                rlast <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (ar_fire) begin
            id_q <= arid;
            word_addr <= araddr[`ISTORE_WORD_ADDR_WIDTH+1:2];
            len_q <= arlen;
            burst_q <= arburst;
        end else if (mem_read_enable) begin
            word_addr <= next_word_addr(word_addr, burst_q, len_q);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/istore_access_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "istore_cfg.svh"

module istore_access_arbiter (
    input logic clock_in,
    input logic reset_in,
    input logic write_request,
    input logic read_request,
    output logic write_grant,
    output logic read_grant,
    input logic mem_write_enable,
    input istore_pkg::word_addr_t mem_write_address,
    input istore_pkg::data_t mem_write_data,
    input logic mem_read_enable,
    input istore_pkg::word_addr_t mem_read_address,
    output istore_pkg::data_t mem_read_data
);
    import istore_pkg::*;

    data_t mem [0:`ISTORE_DEPTH-1]; // instruction RAM

    // one burst owns the store at a time
    always_ff @(posedge clock_in) begin
        if (!reset_in) begin
            write_grant <= 1'b0;
            read_grant <= 1'b0;
        end else if (!write_grant && !read_grant) begin
            write_grant <= write_request; // writes win ties
            read_grant <= !write_request && read_request;
        end else begin
            // hold until the owner lets go
            if (write_grant && !write_request) begin
                write_grant <= 1'b0;
            end
            if (read_grant && !read_request) begin
                read_grant <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (mem_write_enable) begin
            mem[mem_write_address] <= mem_write_data;
        end
    end

    // registered read port, keeps last word when idle
    always_ff @(posedge clock_in) begin
        if (mem_read_enable) begin
            mem_read_data <= mem[mem_read_address];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/istore_axi_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module istore_axi_top (
    input logic clock_in,
    input logic reset_in,
    input istore_pkg::axi_id_t awid,
    input istore_pkg::axi_addr_t awaddr,
    input istore_pkg::burst_len_t awlen,
    input istore_pkg::burst_t awburst,
    input logic awvalid,
    output logic awready,
    input istore_pkg::data_t wdata,
    input logic wlast,
    input logic wvalid,
    output logic wready,
    output istore_pkg::axi_id_t bid,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    input istore_pkg::axi_id_t arid,
    input istore_pkg::axi_addr_t araddr,
    input istore_pkg::burst_len_t arlen,
    input istore_pkg::burst_t arburst,
    input logic arvalid,
    output logic arready,
    output istore_pkg::axi_id_t rid,
    output istore_pkg::data_t rdata,
    output logic [1:0] rresp,
    output logic rlast,
    output logic rvalid,
    input logic rready
);
    import istore_pkg::*;

    logic write_request;
    logic write_grant;
    logic read_request;
    logic read_grant;
    logic mem_write_enable;
    word_addr_t mem_write_address;
    data_t mem_write_data;
    logic mem_read_enable;
    word_addr_t mem_read_address;
    data_t mem_read_data;

    istore_write_channel write_channel (
        .clock_in, .reset_in,
        .awid, .awaddr, .awlen, .awburst, .awvalid, .awready,
        .wdata, .wlast, .wvalid, .wready,
        .bid, .bresp, .bvalid, .bready,
        .write_request, .write_grant,
        .mem_write_enable, .mem_write_address, .mem_write_data
    );

    istore_read_channel read_channel (
        .clock_in, .reset_in,
        .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
        .read_request, .read_grant,
        .mem_read_enable, .mem_read_address, .mem_read_data
    );

    // store and ownership
    istore_access_arbiter access_arbiter (
        .clock_in, .reset_in,
        .write_request, .read_request, .write_grant, .read_grant,
        .mem_write_enable, .mem_write_address, .mem_write_data,
        .mem_read_enable, .mem_read_address, .mem_read_data
    );

endmodule

`default_nettype wire

// ==== test/istore_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "istore_cfg.svh"

module istore_tb;
    import istore_pkg::*;

    // budget of 17 beats at 8 cycles for each transaction
    localparam int num_transactions = 64;
    localparam int timeout_cycles = num_transactions * 17 * 8 + 500;

    logic clock_in;
    logic reset_in;
    axi_id_t awid;
    axi_addr_t awaddr;
    burst_len_t awlen;
    burst_t awburst;
    logic awvalid;
    logic awready;
    data_t wdata;
    logic wlast;
    logic wvalid;
    logic wready;
    axi_id_t bid;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    axi_id_t arid;
    axi_addr_t araddr;
    burst_len_t arlen;
    burst_t arburst;
    logic arvalid;
    logic arready;
    axi_id_t rid;
    data_t rdata;
    logic [1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready;

    data_t model [0:`ISTORE_DEPTH-1]; // expected store contents
    logic [31:0] lfsr = 32'h4a1;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_checks = 0; // counts at the start of the current test
    int test_errors = 0;
    int write_count = 0; // B transfers seen so far

    istore_axi_top dut (
        .clock_in, .reset_in,
        .awid, .awaddr, .awlen, .awburst, .awvalid, .awready,
        .wdata, .wlast, .wvalid, .wready,
        .bid, .bresp, .bvalid, .bready,
        .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready
    );

    always #50 clock_in = ~clock_in;

    always @(posedge clock_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        rand_bits = r;
    endfunction

    // word touched by a given beat of a burst
    function automatic word_addr_t beat_addr(input word_addr_t start, input burst_t burst,
                                             input burst_len_t len, input int beat);
        int size;
        int base;
        size = int'(len) + 1;
        base = (int'(start) / size) * size;
        if (burst == 2'b00) begin
            beat_addr = start;
        end else if (burst == 2'b10) begin
            beat_addr = word_addr_t'(base + (int'(start) - base + beat) % size);
        end else begin
            beat_addr = word_addr_t'((int'(start) + beat) % `ISTORE_DEPTH);
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: actual %h expected %h", name, actual, expected);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s done: %0d checks, %0d failures", name, check_count - test_checks,
                 error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic write_burst(input axi_id_t id, input axi_addr_t addr,
                               input burst_len_t len, input burst_t burst);
        data_t d;
        logic done;
        word_addr_t start;
        start = addr[`ISTORE_WORD_ADDR_WIDTH+1:2];
        awid = id;
        awaddr = addr;
        awlen = len;
        awburst = burst;
        awvalid = 1'b1;
        while (!awready) @(negedge clock_in);
        @(negedge clock_in);
        awvalid = 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            while (rand_bits(2) == 32'd0) begin // random wvalid gap
                wvalid = 1'b0;
                @(negedge clock_in);
            end
            d = rand_bits(32);
            wdata = d;
            wlast = (beat == int'(len));
            wvalid = 1'b1;
            while (!wready) @(negedge clock_in);
            @(negedge clock_in);
            model[beat_addr(start, burst, len, beat)] = d;
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        done = 1'b0;
        while (!done) begin
            bready = (rand_bits(2) != 32'd0); // stall now and then
            if (bvalid && bready) begin
                check_value("bid", 32'(bid), 32'(id));
                check_value("bresp", 32'(bresp), 32'd0);
                write_count++;
                done = 1'b1;
            end
            @(negedge clock_in);
        end
        bready = 1'b0;
    endtask

    task automatic read_burst(input axi_id_t id, input axi_addr_t addr,
                              input burst_len_t len, input burst_t burst);
        int beat;
        word_addr_t start;
        start = addr[`ISTORE_WORD_ADDR_WIDTH+1:2];
        arid = id;
        araddr = addr;
        arlen = len;
        arburst = burst;
        arvalid = 1'b1;
        while (!arready) @(negedge clock_in);
        @(negedge clock_in);
        arvalid = 1'b0;
        beat = 0;
        while (beat <= int'(len)) begin
            rready = (rand_bits(2) != 32'd0);
            if (rvalid) begin // also catches rdata moving under a stall
                check_value("rdata", rdata, model[beat_addr(start, burst, len, beat)]);
                check_value("rlast", 32'(rlast), 32'(beat == int'(len)));
                check_value("rid", 32'(rid), 32'(id));
                check_value("rresp", 32'(rresp), 32'd0);
                if (rready) begin
                    beat++;
                end
            end
            @(negedge clock_in);
        end
        rready = 1'b0;
    endtask

    task automatic write_then_read(input axi_addr_t addr, input burst_len_t len,
                                   input burst_t burst);
        write_burst(axi_id_t'(rand_bits(4)), addr, len, burst);
        read_burst(axi_id_t'(rand_bits(4)), addr, len, burst);
    endtask

    initial begin
        axi_addr_t a;
        burst_len_t len;
        burst_t burst;
        int base;
        int start;
        int writes_before;
        clock_in = 1'b0;
        reset_in = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awburst = '0;
        awvalid = 1'b0;
        wdata = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arburst = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (5) @(negedge clock_in);
        reset_in = 1'b1;

        // whole store gets known data first
        for (int i = 0; i < 16; i++) begin
            write_burst(axi_id_t'(rand_bits(4)), axi_addr_t'(i * 64), 8'd15, 2'b01);
        end
        report_test("fill");

        for (int i = 0; i < 6; i++) begin
            write_then_read(axi_addr_t'(rand_bits(16)), burst_len_t'(rand_bits(4)), 2'b01);
        end
        write_then_read(axi_addr_t'(250 * 4), 8'd15, 2'b01); // runs past the top word
        report_test("incr");

        a = axi_addr_t'(rand_bits(16));
        len = burst_len_t'(rand_bits(3)) + 8'd1; // at least two beats on one word
        write_burst(axi_id_t'(rand_bits(4)), a, len, 2'b00);
        read_burst(axi_id_t'(rand_bits(4)), a, 8'd0, 2'b01);
        report_test("fixed");

        for (int size = 2; size <= 16; size = size * 2) begin
            base = (int'(rand_bits(8)) / size) * size;
            start = base + int'(rand_bits(4)) % (size - 1) + 1; // never the window start
            len = burst_len_t'(size - 1);
            write_then_read(axi_addr_t'(start * 4), len, 2'b10);
            read_burst(axi_id_t'(rand_bits(4)), axi_addr_t'(base * 4), len, 2'b01);
        end
        report_test("wrap");

        for (int i = 0; i < 8; i++) begin
            burst = burst_t'(rand_bits(2)); // reserved code included
            len = burst_len_t'(rand_bits(4));
            if (burst == 2'b10) begin
                len = burst_len_t'((2 << rand_bits(2)) - 1);
            end
            write_then_read(axi_addr_t'(rand_bits(16)), len, burst);
        end
        report_test("random");

        // AW and AR in the same cycle to one range
        a = axi_addr_t'(rand_bits(16));
        len = burst_len_t'(rand_bits(2));
        writes_before = write_count;
        fork
            write_burst(axi_id_t'(4'h3), a, len, 2'b01);
            read_burst(axi_id_t'(4'hc), a, len, 2'b01);
            begin
                while (!rvalid) @(negedge clock_in);
                // the write owns the store first
                check_value("writes_done", 32'(write_count), 32'(writes_before + 1));
            end
        join
        report_test("collide");

        $display("total: %0d checks, %0d failures", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== istore.f ====
+incdir+.
verilog/istore_pkg.sv
verilog/istore_write_channel.sv
verilog/istore_read_channel.sv
verilog/istore_access_arbiter.sv
verilog/istore_axi_top.sv
test/istore_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the instruction store testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps --top-module istore_tb \
    -f istore.f --Mdir obj_dir -o istore_sim

./obj_dir/istore_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
